// ==== common/tcp_rx_macros.svh ====
////////////////////////////////////////////////////////////////////////////
// tcp receive reassembly sizing
// receive window depth, reported sack block count and byte width
////////////////////////////////////////////////////////////////////////////
`ifndef TCP_RX_MACROS_SVH
`define TCP_RX_MACROS_SVH

// ram address width, the window is 2**RX_RAM_AW bytes
`define RX_RAM_AW 5

// sack blocks remembered and reported
`define SACK_BLOCKS 4

// width of one payload byte
`define RX_DW 8

`endif

// ==== common/tcp_rx_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// tcp receive reassembly types
// sequence numbers, sack blocks, the sack option and tracker states
////////////////////////////////////////////////////////////////////////////
`include "tcp_rx_macros.svh"

package tcp_rx_pkg;

  // sequence or acknowledgement number, wraps modulo 2**32
  typedef logic [31:0] tcp_num_t;

  // one sack block
  // left is the first byte held, right is one past the last byte
  typedef struct packed {
    tcp_num_t left;
    tcp_num_t right;
  } tcp_sack_block_t;

  // sack option as reported to the sender
  // block 0 is reported first, block_pres flags the valid entries
  typedef struct packed {
    tcp_sack_block_t [0:`SACK_BLOCKS-1] block;
    logic            [0:`SACK_BLOCKS-1] block_pres;
  } tcp_opt_sack_t;

  // sack tracker states
  typedef enum logic [2:0] {
    idle_s,  // wait for a segment
    gap_s,   // window check and in-order test
    cal_s,   // compare new block with one remembered block
    cat_s,   // absorb or keep that block
    out_s,   // in-order result, advance loc_ack
    upd_s    // out-of-order result, new block goes first
  } sack_state_t;

endpackage

// ==== logic/rx_byte_ram.sv ====
////////////////////////////////////////////////////////////////////////////
// receive byte ram
// dual-port storage, port a writes, port b reads with one cycle latency
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "tcp_rx_macros.svh"

module rx_byte_ram #(
  parameter int AW = `RX_RAM_AW,
  parameter int DW = `RX_DW
) (
  input  logic          clk,
  input  logic [AW-1:0] a_addr,
  input  logic [DW-1:0] a_data,
  input  logic          a_wr,
  input  logic [AW-1:0] b_addr,
  output logic [DW-1:0] b_q
);

  // one byte per sequence offset inside the window
  logic [DW-1:0] mem [2**AW];

  // port a, write only
  always_ff @(posedge clk) begin
    if (a_wr) begin
      mem[a_addr] <= a_data;
    end
  end

  // port b, registered read
  always_ff @(posedge clk) begin
    b_q <= mem[b_addr];
  end

endmodule

// ==== sack/tcp_sack_tracker.sv ====
////////////////////////////////////////////////////////////////////////////
// tcp sack tracker
// window check per segment, merge with remembered sack blocks,
// local acknowledgement update when an in-order segment arrives
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "tcp_rx_macros.svh"

module tcp_sack_tracker (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     init,
  input  tcp_rx_pkg::tcp_num_t     init_ack,
  input  logic                     pkt_val,
  input  tcp_rx_pkg::tcp_num_t     pkt_start,
  input  tcp_rx_pkg::tcp_num_t     pkt_stop,
  input  tcp_rx_pkg::tcp_num_t     rd_ack,
  output tcp_rx_pkg::tcp_num_t     loc_ack,
  output tcp_rx_pkg::tcp_opt_sack_t sack,
  output logic                     store,
  output logic [`RX_RAM_AW-1:0]    wr_base
);

  import tcp_rx_pkg::*;

  localparam int unsigned NB = `SACK_BLOCKS;
  localparam int CW = $clog2(NB + 1);
  // receive window size in bytes
  localparam tcp_num_t WIN = tcp_num_t'(1) << `RX_RAM_AW;

  sack_state_t     state;

  // window check, sign bit set means outside the window
  tcp_num_t        start_gap;
  tcp_num_t        stop_gap;
  tcp_num_t        win_top;

  // merge comparison, all taken modulo 2**32
  tcp_num_t        left_dif;
  tcp_num_t        right_dif;
  tcp_num_t        start_dif;
  tcp_num_t        stop_dif;
  logic            touch;

  tcp_sack_block_t new_block;
  tcp_sack_block_t cur_block;
  // working copy of sack, shifted one block per cal visit
  tcp_opt_sack_t   cur_sack;
  // blocks not absorbed, in their original order
  tcp_opt_sack_t   new_sack;
  logic [CW-1:0]   blk_num;
  logic [CW-1:0]   kept_cnt;
  logic            in_order;

  // top of the window is the read pointer plus ram depth
  assign win_top = rd_ack + WIN;

  // blocks share a byte or one starts right where the other stops
  assign touch = !start_dif[31] && !stop_dif[31];

  ////////////////////////////////////////////////////////////////////////////
  // datapath registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    case (state)
      idle_s: begin
        // bottom gap, start must not lie below rd_ack
        start_gap      <= pkt_start - rd_ack;
        // top gap, stop must not pass the end of the ram
        stop_gap       <= win_top - pkt_stop;
        new_block.left  <= pkt_start;
        new_block.right <= pkt_stop;
        // held through the pass for the write side
        wr_base        <= pkt_start[`RX_RAM_AW-1:0];
      end
      cal_s: begin
        cur_block <= cur_sack.block[0];
        // sign set -> new block starts below the old one
        left_dif  <= new_block.left - cur_sack.block[0].left;
        // sign set -> new block stops above the old one
        right_dif <= cur_sack.block[0].right - new_block.right;
        start_dif <= cur_sack.block[0].right - new_block.left;
        stop_dif  <= new_block.right - cur_sack.block[0].left;
      end
      cat_s: begin
        // widen the new block to the union
        if (touch) begin
          new_block.left  <= left_dif[31] ? new_block.left : cur_block.left;
          new_block.right <= right_dif[31] ? new_block.right : cur_block.right;
        end
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // control fsm
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= idle_s;
      store    <= 1'b0;
      in_order <= 1'b0;
      blk_num  <= '0;
      kept_cnt <= '0;
      loc_ack  <= '0;
      sack     <= '0;
      cur_sack <= '0;
      new_sack <= '0;
    end else if (init) begin
      // fresh connection, nothing remembered
      loc_ack <= init_ack;
      sack    <= '0;
      store   <= 1'b0;
      state   <= idle_s;
    end else begin
      case (state)
        idle_s: begin
          in_order            <= 1'b0;
          blk_num             <= '0;
          kept_cnt            <= '0;
          new_sack.block_pres <= '0;
          if (pkt_val) begin
            state <= gap_s;
          end
        end
        gap_s: begin
          in_order <= (new_block.left == loc_ack);
          cur_sack <= sack;
          if (!start_gap[31] && !stop_gap[31]) begin
            store <= 1'b1;
            state <= cal_s;
          end else begin
            // outside the window, segment dropped
            state <= idle_s;
          end
        end
        cal_s: begin
          // move the next remembered block to position 0
          for (int i = 0; i < NB - 1; i++) begin
            cur_sack.block[i]      <= cur_sack.block[i+1];
            cur_sack.block_pres[i] <= cur_sack.block_pres[i+1];
          end
          cur_sack.block_pres[NB-1] <= 1'b0;
          blk_num <= blk_num + 1'b1;
          if (cur_sack.block_pres[0]) begin
            state <= cat_s;
          end else if (blk_num == CW'(NB - 1)) begin
            state <= in_order ? out_s : upd_s;
          end
        end
        cat_s: begin
          // a block that does not touch is kept in order
          if (!touch) begin
            new_sack.block[kept_cnt]      <= cur_block;
            new_sack.block_pres[kept_cnt] <= 1'b1;
            kept_cnt                      <= kept_cnt + 1'b1;
          end
          if (blk_num == CW'(NB)) begin
            state <= in_order ? out_s : upd_s;
          end else begin
            state <= cal_s;
          end
        end
        out_s: begin
          // gap closed up to the merged right edge
          loc_ack <= new_block.right;
          sack    <= new_sack;
          store   <= 1'b0;
          state   <= idle_s;
        end
        upd_s: begin
          // newest block reported first, oldest kept one falls off
          sack.block[0]      <= new_block;
          sack.block_pres[0] <= 1'b1;
          for (int i = 1; i < NB; i++) begin
            sack.block[i]      <= new_sack.block[i-1];
            sack.block_pres[i] <= new_sack.block_pres[i-1];
          end
          store <= 1'b0;
          state <= idle_s;
        end
        default: begin
          state <= idle_s;
        end
      endcase
    end
  end

endmodule

// ==== sack/tcp_rx_queue.sv ====
////////////////////////////////////////////////////////////////////////////
// tcp receive queue
// writes accepted payload at its sequence offset, streams bytes out
// in order as the acknowledgement number advances
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "tcp_rx_macros.svh"

module tcp_rx_queue (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  init,
  input  tcp_rx_pkg::tcp_num_t  init_ack,
  input  logic                  connected,
  input  logic                  store,
  input  logic [`RX_RAM_AW-1:0] wr_base,
  input  tcp_rx_pkg::tcp_num_t  loc_ack,
  input  logic                  strm_val,
  input  logic                  strm_sof,
  input  logic [`RX_DW-1:0]     strm_dat,
  output tcp_rx_pkg::tcp_num_t  rd_ack,
  output logic                  data_val,
  output logic [`RX_DW-1:0]     data_dat
);

  // two-stage stream delay, first byte lines up with store
  logic [1:0]            val_d;
  logic [1:0]            sof_d;
  logic [`RX_DW-1:0]     dat_d [2];

  // ram port a
  logic [`RX_RAM_AW-1:0] a_addr;
  logic [`RX_DW-1:0]     a_data;
  logic                  a_wr;
  // ram port b data
  logic [`RX_DW-1:0]     b_q;
  // a read was issued last cycle
  logic                  out_en;

  rx_byte_ram #(
    .AW (`RX_RAM_AW),
    .DW (`RX_DW)
  ) u_ram (
    .clk    (clk),
    .a_addr (a_addr),
    .a_data (a_data),
    .a_wr   (a_wr),
    .b_addr (rd_ack[`RX_RAM_AW-1:0]),
    .b_q    (b_q)
  );

  ////////////////////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      val_d <= '0;
      sof_d <= '0;
      a_wr  <= 1'b0;
    end else begin
      val_d <= {val_d[0], strm_val};
      sof_d <= {sof_d[0], strm_sof};
      // write only segments the tracker accepted
      if (sof_d[1]) begin
        a_wr <= store;
      end else if (!val_d[1]) begin
        a_wr <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    dat_d[0] <= strm_dat;
    dat_d[1] <= dat_d[0];
    a_data   <= dat_d[1];
    // first byte goes to the segment offset, then one up per byte
    if (sof_d[1]) begin
      a_addr <= wr_base;
    end else if (val_d[1]) begin
      a_addr <= a_addr + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ack   <= '0;
      out_en   <= 1'b0;
      data_val <= 1'b0;
    end else begin
      data_val <= out_en;
      if (init) begin
        rd_ack <= init_ack;
        out_en <= 1'b0;
      end else if (connected && (rd_ack != loc_ack)) begin
        // chase loc_ack one byte per cycle
        rd_ack <= rd_ack + 1'b1;
        out_en <= 1'b1;
      end else begin
        out_en <= 1'b0;
      end
    end
  end

  // ram output lines up with data_val
  always_ff @(posedge clk) begin
    data_dat <= b_q;
  end

endmodule

// ==== logic/tcp_rx_reasm.sv ====
////////////////////////////////////////////////////////////////////////////
// tcp receive reassembly top
// joins the sack tracker and the receive queue so that
// out-of-order bytes come out in order
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "tcp_rx_macros.svh"

module tcp_rx_reasm (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      init,
  input  tcp_rx_pkg::tcp_num_t      init_ack,
  input  logic                      connected,
  input  logic                      pkt_val,
  input  tcp_rx_pkg::tcp_num_t      pkt_start,
  input  tcp_rx_pkg::tcp_num_t      pkt_stop,
  input  logic                      strm_val,
  input  logic                      strm_sof,
  input  logic [`RX_DW-1:0]         strm_dat,
  output tcp_rx_pkg::tcp_num_t      loc_ack,
  output tcp_rx_pkg::tcp_opt_sack_t sack,
  output logic                      store,
  output logic                      data_val,
  output logic [`RX_DW-1:0]         data_dat
);

  import tcp_rx_pkg::*;

  // ram offset of the current segment
  logic [`RX_RAM_AW-1:0] wr_base;
  // read pointer and bottom of the receive window
  tcp_num_t              rd_ack;

  tcp_sack_tracker u_tracker (
    .clk       (clk),
    .rst_n     (rst_n),
    .init      (init),
    .init_ack  (init_ack),
    .pkt_val   (pkt_val),
    .pkt_start (pkt_start),
    .pkt_stop  (pkt_stop),
    .rd_ack    (rd_ack),
    .loc_ack   (loc_ack),
    .sack      (sack),
    .store     (store),
    .wr_base   (wr_base)
  );

  tcp_rx_queue u_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .init      (init),
    .init_ack  (init_ack),
    .connected (connected),
    .store     (store),
    .wr_base   (wr_base),
    .loc_ack   (loc_ack),
    .strm_val  (strm_val),
    .strm_sof  (strm_sof),
    .strm_dat  (strm_dat),
    .rd_ack    (rd_ack),
    .data_val  (data_val),
    .data_dat  (data_dat)
  );

endmodule

// ==== tb/tcp_rx_model.svh ====
////////////////////////////////////////////////////////////////////////////
// receive reassembly reference model
// payload byte generator, window rule and sack merge rule
////////////////////////////////////////////////////////////////////////////
`ifndef TCP_RX_MODEL_SVH
`define TCP_RX_MODEL_SVH

  // expected acknowledgement number and sack blocks
  tcp_num_t exp_ack;
  tcp_num_t exp_left  [`SACK_BLOCKS];
  tcp_num_t exp_right [`SACK_BLOCKS];
  logic     exp_pres  [`SACK_BLOCKS];

  // 32-bit xorshift, source of payload bytes
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // a lies before b in sequence space, modulo 2**32
  function automatic logic seq_before(input tcp_num_t a, input tcp_num_t b);
    tcp_num_t d;
    d = a - b;
    return d[31];
  endfunction

  // segment must start at or above the bottom and end within one window
  function automatic logic in_window(input tcp_num_t bottom, input tcp_num_t start,
                                     input tcp_num_t stop);
    tcp_num_t top;
    top = bottom + (tcp_num_t'(1) << `RX_RAM_AW);
    return !seq_before(start, bottom) && !seq_before(top, stop);
  endfunction

  // fresh connection, nothing remembered
  task automatic model_init(input tcp_num_t ack);
    exp_ack = ack;
    for (int i = 0; i < `SACK_BLOCKS; i++) begin
      exp_pres[i] = 1'b0;
    end
  endtask

  // accepted segment against the remembered blocks
  task automatic merge_reference(input tcp_num_t left, input tcp_num_t right);
    tcp_num_t new_l;
    tcp_num_t new_r;
    tcp_num_t kept_l [`SACK_BLOCKS];
    tcp_num_t kept_r [`SACK_BLOCKS];
    int       kept;
    logic     in_seq;
    new_l  = left;
    new_r  = right;
    kept   = 0;
    in_seq = (left == exp_ack);
    for (int i = 0; i < `SACK_BLOCKS; i++) begin
      if (exp_pres[i]) begin
        // overlap or adjacency absorbs the block
        if (!seq_before(exp_right[i], new_l) && !seq_before(new_r, exp_left[i])) begin
          if (seq_before(exp_left[i], new_l)) begin
            new_l = exp_left[i];
          end
          if (seq_before(new_r, exp_right[i])) begin
            new_r = exp_right[i];
          end
        end else begin
          kept_l[kept] = exp_left[i];
          kept_r[kept] = exp_right[i];
          kept++;
        end
      end
    end
    for (int i = 0; i < `SACK_BLOCKS; i++) begin
      exp_pres[i] = 1'b0;
    end
    if (in_seq) begin
      // gap closed, ack jumps to the merged edge
      exp_ack = new_r;
      for (int i = 0; i < kept; i++) begin
        exp_left[i]  = kept_l[i];
        exp_right[i] = kept_r[i];
        exp_pres[i]  = 1'b1;
      end
    end else begin
      // newest block first, kept ones behind it
      exp_left[0]  = new_l;
      exp_right[0] = new_r;
      exp_pres[0]  = 1'b1;
      for (int i = 0; i < kept && i < `SACK_BLOCKS - 1; i++) begin
        exp_left[i+1]  = kept_l[i];
        exp_right[i+1] = kept_r[i];
        exp_pres[i+1]  = 1'b1;
      end
    end
  endtask

`endif

// ==== tb/tb_tcp_rx_reasm.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for the tcp receive reassembly top
// in-order, out-of-order, merge, gap fill and window drop segments
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "tcp_rx_macros.svh"

module tb_tcp_rx_reasm;

  import tcp_rx_pkg::*;

  localparam int       CLK_PERIOD   = 10;
  localparam int       RESET_CYCLES = 16;
  localparam int       WIN          = 2 ** `RX_RAM_AW;
  localparam int       SPACING      = 16;
  localparam int       NUM_SEGS     = 9;
  // longest segment, spacing, read-out limit and slack
  localparam int       SEG_BUDGET   = WIN + SPACING + 2 * WIN + 8;
  localparam int       WATCHDOG_CYCLES = RESET_CYCLES + 16 + NUM_SEGS * SEG_BUDGET + 100;
  // sequence space wraps through zero during the run
  localparam tcp_num_t INIT_ACK     = 32'hffff_ffe8;

  logic              clk;
  logic              rst_n;
  logic              init;
  tcp_num_t          init_ack;
  logic              connected;
  logic              pkt_val;
  tcp_num_t          pkt_start;
  tcp_num_t          pkt_stop;
  logic              strm_val;
  logic              strm_sof;
  logic [`RX_DW-1:0] strm_dat;
  tcp_num_t          loc_ack;
  tcp_opt_sack_t     sack;
  logic              store;
  logic              data_val;
  logic [`RX_DW-1:0] data_dat;

  // bytes by sequence number, low 10 bits
  logic [7:0]  model_mem [0:1023];
  logic [31:0] rand_state;
  logic [1:0]  pv_hist;
  logic        store_q;
  logic        exp_accept;
  tcp_num_t    exp_rd;
  int          dlv_cnt;
  int          err_cnt;
  int          test_err_base;
  int          tests_run;
  int          tests_failed;

  `include "tcp_rx_model.svh"

  tcp_rx_reasm dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .init      (init),
    .init_ack  (init_ack),
    .connected (connected),
    .pkt_val   (pkt_val),
    .pkt_start (pkt_start),
    .pkt_stop  (pkt_stop),
    .strm_val  (strm_val),
    .strm_sof  (strm_sof),
    .strm_dat  (strm_dat),
    .loc_ack   (loc_ack),
    .sack      (sack),
    .store     (store),
    .data_val  (data_val),
    .data_dat  (data_dat)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // checking helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input tcp_num_t got, input tcp_num_t exp);
    assert (got === exp) else begin
      err_cnt++;
      $display("mismatch at %0t: %0s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // loc_ack and every sack block against the model
  task automatic check_state(input string where);
    check_value({where, " loc_ack"}, loc_ack, exp_ack);
    for (int i = 0; i < `SACK_BLOCKS; i++) begin
      check_value($sformatf("%0s block %0d present", where, i),
                  sack.block_pres[i], exp_pres[i]);
      if (exp_pres[i]) begin
        check_value($sformatf("%0s block %0d left", where, i), sack.block[i].left,
                    exp_left[i]);
        check_value($sformatf("%0s block %0d right", where, i), sack.block[i].right,
                    exp_right[i]);
      end
    end
  endtask

  // store timing, 2 cycles after pkt_val and only for accepted segments
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pv_hist <= '0;
      store_q <= 1'b0;
      exp_rd  <= '0;
      dlv_cnt <= 0;
    end else begin
      pv_hist <= {pv_hist[0], pkt_val};
      store_q <= store;
      if (pv_hist[1]) begin
        check_value("store 2 cycles after pkt_val", store, exp_accept);
      end
      assert (!(store && !store_q) || pv_hist[1]) else begin
        err_cnt++;
        $display("error at %0t: store rose without a segment 2 cycles before", $time);
      end
      if (init) begin
        exp_rd <= init_ack;
      end
      // user stream in sequence order, never past loc_ack
      if (data_val) begin
        assert (exp_rd != exp_ack) else begin
          err_cnt++;
          $display("error at %0t: user byte delivered beyond the acknowledged data", $time);
        end
        check_value("user byte", data_dat, model_mem[exp_rd[9:0]]);
        exp_rd  <= exp_rd + 1'b1;
        dlv_cnt <= dlv_cnt + 1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  // one segment, then the spacing gap and a state check
  task automatic send_segment(input tcp_num_t start, input int len);
    logic [7:0] payload [2*WIN];
    tcp_num_t   stop;
    tcp_num_t   idx;
    @(negedge clk);
    stop       = start + len;
    exp_accept = in_window(exp_ack, start, stop);
    for (int i = 0; i < len; i++) begin
      rand_state = xorshift32(rand_state);
      payload[i] = rand_state[7:0];
      idx        = start + i;
      if (exp_accept) begin
        model_mem[idx[9:0]] = payload[i];
      end
    end
    if (exp_accept) begin
      merge_reference(start, stop);
    end
    @(posedge clk);
    pkt_val   <= 1'b1;
    pkt_start <= start;
    pkt_stop  <= stop;
    strm_val  <= 1'b1;
    strm_sof  <= 1'b1;
    strm_dat  <= payload[0];
    for (int i = 1; i < len; i++) begin
      @(posedge clk);
      pkt_val  <= 1'b0;
      strm_sof <= 1'b0;
      strm_dat <= payload[i];
    end
    @(posedge clk);
    pkt_val  <= 1'b0;
    strm_val <= 1'b0;
    strm_sof <= 1'b0;
    repeat (SPACING) @(posedge clk);
    // merge pass over, results settled
    check_value("store after merge pass", store, 1'b0);
    check_state($sformatf("segment %h", start));
  endtask

  // wait until the user stream catches up with the model ack
  task automatic drain_stream(input int base, input int expected);
    int n;
    n = 0;
    while (exp_rd != exp_ack && n < 2 * WIN) begin
      @(posedge clk);
      n++;
    end
    if (exp_rd != exp_ack) begin
      err_cnt++;
      $display("error at %0t: user stream stalled before reaching loc_ack", $time);
    end
    check_value("user byte count", dlv_cnt - base, expected);
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_cnt == test_err_base) begin
      $display("test %0s: ok", name);
    end else begin
      tests_failed++;
      $display("test %0s: %0d errors", name, err_cnt - test_err_base);
    end
    test_err_base = err_cnt;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    tcp_num_t b;
    int       base;
    rst_n      = 1'b0;
    init       = 1'b0;
    init_ack   = '0;
    connected  = 1'b0;
    pkt_val    = 1'b0;
    pkt_start  = '0;
    pkt_stop   = '0;
    strm_val   = 1'b0;
    strm_sof   = 1'b0;
    strm_dat   = '0;
    rand_state = 32'd10791;
    exp_accept = 1'b0;
    err_cnt    = 0;
    tests_run  = 0;
    tests_failed  = 0;
    test_err_base = 0;
    model_init('0);
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // reset values, then init loads the ack
    check_value("store after reset", store, 1'b0);
    check_value("data_val after reset", data_val, 1'b0);
    check_value("sack presence after reset", sack.block_pres, '0);
    check_value("loc_ack after reset", loc_ack, '0);
    @(posedge clk);
    init      <= 1'b1;
    init_ack  <= INIT_ACK;
    connected <= 1'b1;
    @(negedge clk);
    model_init(INIT_ACK);
    @(posedge clk);
    init <= 1'b0;
    @(posedge clk);
    check_value("loc_ack after init", loc_ack, INIT_ACK);
    end_test("reset_init");

    base = dlv_cnt;
    send_segment(exp_ack, 12);
    drain_stream(base, 12);
    end_test("in_order");

    // b stays the ack until the gap is filled
    b    = exp_ack;
    base = dlv_cnt;
    send_segment(b + 8, 6);
    drain_stream(base, 0);
    end_test("out_of_order");

    base = dlv_cnt;
    // touching, then overlapping inside, then disjoint
    send_segment(b + 14, 4);
    send_segment(b + 10, 4);
    send_segment(b + 22, 5);
    drain_stream(base, 0);
    end_test("merge");

    base = dlv_cnt;
    send_segment(b, 8);
    drain_stream(base, 18);
    base = dlv_cnt;
    send_segment(b + 18, 4);
    drain_stream(base, 9);
    end_test("gap_fill");

    b    = exp_ack;
    base = dlv_cnt;
    // below the ack, then past the top of the window
    send_segment(b - 4, 8);
    send_segment(b + 10, 30);
    drain_stream(base, 0);
    end_test("window_drop");

    $display("tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // watchdog sized from the segment budget
  initial begin : watchdog
    sack_state_t st;
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    st = dut.u_tracker.state;
    $display("timeout: run did not end within %0d cycles, tracker in state %0s",
             WATCHDOG_CYCLES, st.name());
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+common
+incdir+tb
common/tcp_rx_pkg.sv
logic/rx_byte_ram.sv
sack/tcp_sack_tracker.sv
sack/tcp_rx_queue.sv
logic/tcp_rx_reasm.sv
tb/tb_tcp_rx_reasm.sv
